/* Makefile */
# Verilator build and run of the load launch pipeline testbench

VERILATOR ?= verilator
TOP       ?= ldu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, status is the simulation result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) hdl/*.sv test/*.sv test/*.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
+incdir+test
hdl/ldu_pkg.sv
hdl/ldu_req_arbiter.sv
hdl/ldu_resp_stage.sv
hdl/ldu_load_align.sv
hdl/ldu_ret_stage.sv
hdl/ldu_launch_pipeline.sv
test/ldu_tb.sv

/* hdl/ldu_launch_pipeline.sv */
// load unit launch pipeline top: request, response and return stages in a row
`timescale 1ns/100ps

module ldu_launch_pipeline (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     first_try_valid,
    input  ldu_pkg::first_try_t      first_try,
    output logic                     first_try_ack,
    input  logic                     data_try_valid,
    input  ldu_pkg::data_try_t       data_try,
    output logic                     data_try_ack,
    output logic                     dtlb_req_valid,
    output ldu_pkg::dtlb_req_t       dtlb_req,
    input  logic                     dtlb_req_ready,
    input  ldu_pkg::dtlb_resp_t      dtlb_resp,
    output logic                     dcache_req_valid,
    output ldu_pkg::dcache_req_t     dcache_req,
    input  logic                     dcache_req_ready,
    input  ldu_pkg::dcache_resp_t    dcache_resp,
    output ldu_pkg::cq_index_t       cq_grab_index,
    input  ldu_pkg::cq_grab_t        cq_grab,
    output logic                     wb_valid,
    output ldu_pkg::wb_t             wb,
    input  logic                     wb_ready,
    output logic                     rob_exception_valid,
    output ldu_pkg::rob_exception_t  rob_exception,
    input  logic                     rob_exception_ready,
    output logic                     cq_ret_valid,
    output ldu_pkg::cq_ret_t         cq_ret
);

    // return-stage stall holds everything upstream
    logic                 stall;
    logic                 ret_valid;
    ldu_pkg::ret_entry_t  ret_entry;

    ldu_req_arbiter u_req (
        .first_try_valid  (first_try_valid),
        .first_try        (first_try),
        .data_try_valid   (data_try_valid),
        .data_try         (data_try),
        .stall            (stall),
        .dtlb_req_ready   (dtlb_req_ready),
        .dcache_req_ready (dcache_req_ready),
        .first_try_ack    (first_try_ack),
        .data_try_ack     (data_try_ack),
        .dtlb_req_valid   (dtlb_req_valid),
        .dtlb_req         (dtlb_req),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req       (dcache_req)
    );

    ldu_resp_stage u_resp (
        .CLK           (CLK),
        .nRST          (nRST),
        .first_try_ack (first_try_ack),
        .data_try_ack  (data_try_ack),
        .first_try     (first_try),
        .data_try      (data_try),
        .dtlb_resp     (dtlb_resp),
        .dcache_resp   (dcache_resp),
        .cq_grab       (cq_grab),
        .stall         (stall),
        .cq_grab_index (cq_grab_index),
        .ret_valid     (ret_valid),
        .ret_entry     (ret_entry)
    );

    ldu_ret_stage u_ret (
        .CLK                 (CLK),
        .nRST                (nRST),
        .resp_valid          (ret_valid),
        .resp_entry          (ret_entry),
        .wb_ready            (wb_ready),
        .rob_exception_ready (rob_exception_ready),
        .stall               (stall),
        .wb_valid            (wb_valid),
        .wb                  (wb),
        .rob_exception_valid (rob_exception_valid),
        .rob_exception       (rob_exception),
        .cq_ret_valid        (cq_ret_valid),
        .cq_ret              (cq_ret)
    );

endmodule

/* hdl/ldu_load_align.sv */
// load result alignment: selects bytes by op and mask and extends them
`timescale 1ns/100ps

module ldu_load_align (
    input  ldu_pkg::load_op_t   op,
    input  ldu_pkg::byte_mask_t byte_mask,
    input  logic                is_data,
    input  ldu_pkg::word_t      data,
    output ldu_pkg::word_t      wb_data
);

    logic [15:0] half;
    logic [7:0]  byte_sel;

    always_comb begin
        // half select, mask 1100 / 0110 / 0011
        if (~byte_mask[1]) begin
            half = data[31:16];
        end else if (~byte_mask[0]) begin
            half = data[23:8];
        end else begin
            half = data[15:0];
        end

        // byte of the highest set mask bit
        if (byte_mask[3]) begin
            byte_sel = data[31:24];
        end else if (byte_mask[2]) begin
            byte_sel = data[23:16];
        end else if (byte_mask[1]) begin
            byte_sel = data[15:8];
        end else begin
            byte_sel = data[7:0];
        end

        if (is_data | op[1]) begin
            wb_data = data;
        end else if (op[0]) begin
            wb_data = {{16{~op[2] & half[15]}}, half};
        end else begin
            wb_data = {{24{~op[2] & byte_sel[7]}}, byte_sel};
        end
    end

endmodule

/* hdl/ldu_pkg.sv */
// shared widths, vector types and port structs for the load launch pipeline
package ldu_pkg;

    // ------------------------------------------------
    // widths
    parameter int VPN_W          = 20;
    parameter int PPN_W          = 22;
    parameter int PO_WORD_W      = 10;
    parameter int PA_WORD_W      = PPN_W + PO_WORD_W;
    parameter int VA_W           = 32;
    parameter int WORD_W         = 32;
    parameter int CQ_INDEX_W     = 3;
    parameter int PR_W           = 7;
    parameter int ROB_INDEX_W    = 7;
    parameter int DCACHE_INDEX_W = 7;
    parameter int DCACHE_OFFSET_W = 5;
    parameter int DCACHE_TAG_W   = 22;
    parameter int DCACHE_WAYS    = 2;
    // word-address bit that picks the dcache bank
    parameter int DCACHE_BANK_BIT = 3;

    // ------------------------------------------------
    // vector types
    typedef logic [VPN_W-1:0]           vpn_t;
    typedef logic [PPN_W-1:0]           ppn_t;
    typedef logic [PO_WORD_W-1:0]       po_word_t;
    typedef logic [PA_WORD_W-1:0]       pa_word_t;
    typedef logic [VA_W-1:0]            va_t;
    typedef logic [WORD_W-1:0]          word_t;
    typedef logic [3:0]                 byte_mask_t;
    // op[1] word, op[0] half, op[2] unsigned
    typedef logic [3:0]                 load_op_t;
    typedef logic [CQ_INDEX_W-1:0]      cq_index_t;
    typedef logic [PR_W-1:0]            pr_t;
    typedef logic [ROB_INDEX_W-1:0]     rob_index_t;
    typedef logic [DCACHE_INDEX_W-1:0]  dcache_index_t;
    typedef logic [DCACHE_OFFSET_W-1:0] dcache_offset_t;
    typedef logic [DCACHE_TAG_W-1:0]    dcache_tag_t;

    // ------------------------------------------------
    // port structs
    typedef struct packed {
        vpn_t       vpn;
        po_word_t   po_word;
        byte_mask_t byte_mask;
        cq_index_t  cq_index;
    } first_try_t;

    typedef struct packed {
        word_t     data;
        cq_index_t cq_index;
    } data_try_t;

    typedef struct packed {
        vpn_t      vpn;
        cq_index_t cq_index;
    } dtlb_req_t;

    typedef struct packed {
        logic hit;
        ppn_t ppn;
        logic page_fault;
        logic access_fault;
    } dtlb_resp_t;

    typedef struct packed {
        dcache_offset_t block_offset;
        dcache_index_t  index;
        cq_index_t      cq_index;
    } dcache_req_t;

    typedef struct packed {
        logic [DCACHE_WAYS-1:0]        valid_by_way;
        dcache_tag_t [DCACHE_WAYS-1:0] tag_by_way;
        word_t [DCACHE_WAYS-1:0]       data_by_way;
    } dcache_resp_t;

    typedef struct packed {
        load_op_t   op;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } cq_grab_t;

    typedef struct packed {
        logic       is_data;
        logic       dtlb_hit;
        logic       dcache_hit;
        logic       page_fault;
        logic       access_fault;
        logic       do_wb;
        logic       do_exception;
        load_op_t   op;
        pr_t        dest_pr;
        rob_index_t rob_index;
        pa_word_t   pa_word;
        byte_mask_t byte_mask;
        word_t      data;
        cq_index_t  cq_index;
    } ret_entry_t;

    typedef struct packed {
        word_t      data;
        pr_t        pr;
        rob_index_t rob_index;
    } wb_t;

    typedef struct packed {
        va_t        va;
        logic       page_fault;
        logic       access_fault;
        rob_index_t rob_index;
    } rob_exception_t;

    typedef struct packed {
        logic       wb_sent;
        cq_index_t  cq_index;
        logic       dtlb_hit;
        logic       page_fault;
        logic       access_fault;
        logic       dcache_hit;
        pa_word_t   pa_word;
        byte_mask_t byte_mask;
        word_t      data;
    } cq_ret_t;

endpackage

/* hdl/ldu_req_arbiter.sv */
// request stage: picks first or data try, acks it, issues dtlb and dcache requests
`timescale 1ns/100ps

module ldu_req_arbiter (
    input  logic                   first_try_valid,
    input  ldu_pkg::first_try_t    first_try,
    input  logic                   data_try_valid,
    input  ldu_pkg::data_try_t     data_try,
    input  logic                   stall,
    input  logic                   dtlb_req_ready,
    input  logic                   dcache_req_ready,
    output logic                   first_try_ack,
    output logic                   data_try_ack,
    output logic                   dtlb_req_valid,
    output ldu_pkg::dtlb_req_t     dtlb_req,
    output logic                   dcache_req_valid,
    output ldu_pkg::dcache_req_t   dcache_req
);

    // --------------------------------------------------
    // priority and ack

    always_comb begin
        // first try needs both request ports free
        first_try_ack = first_try_valid & ~stall & dtlb_req_ready & dcache_req_ready;
        data_try_ack  = data_try_valid & ~stall & ~first_try_ack;
    end

    // --------------------------------------------------
    // dtlb and dcache requests

    always_comb begin
        dtlb_req_valid   = first_try_ack;
        dtlb_req.vpn      = first_try.vpn;
        dtlb_req.cq_index = first_try.cq_index;

        dcache_req_valid = first_try_ack;
        // word bits below the bank bit, then byte bits
        dcache_req.block_offset = {first_try.po_word[ldu_pkg::DCACHE_BANK_BIT-1:0], 2'b00};
        // set index sits above the bank bit, top index bit is zero within a page
        dcache_req.index = ldu_pkg::dcache_index_t'(
            first_try.po_word[ldu_pkg::PO_WORD_W-1:ldu_pkg::DCACHE_BANK_BIT+1]);
        dcache_req.cq_index = first_try.cq_index;
    end

endmodule

/* hdl/ldu_resp_stage.sv */
// response stage: holds the launched try, merges dtlb/dcache responses and cq info
`timescale 1ns/100ps

module ldu_resp_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   first_try_ack,
    input  logic                   data_try_ack,
    input  ldu_pkg::first_try_t    first_try,
    input  ldu_pkg::data_try_t     data_try,
    input  ldu_pkg::dtlb_resp_t    dtlb_resp,
    input  ldu_pkg::dcache_resp_t  dcache_resp,
    input  ldu_pkg::cq_grab_t      cq_grab,
    input  logic                   stall,
    output ldu_pkg::cq_index_t     cq_grab_index,
    output logic                   ret_valid,
    output ldu_pkg::ret_entry_t    ret_entry
);

    logic                   stage_valid;
    logic                   stage_is_data;
    ldu_pkg::first_try_t    stage_first;
    ldu_pkg::data_try_t     stage_data;

    logic                   first_cycle;
    ldu_pkg::dtlb_resp_t    saved_dtlb;
    ldu_pkg::dcache_resp_t  saved_dcache;
    ldu_pkg::dtlb_resp_t    sel_dtlb;
    ldu_pkg::dcache_resp_t  sel_dcache;

    logic                   dtlb_hit;
    logic                   page_fault;
    logic                   access_fault;
    ldu_pkg::ppn_t          ppn;
    ldu_pkg::pa_word_t      pa_word;
    ldu_pkg::dcache_tag_t   pa_tag;
    logic [ldu_pkg::DCACHE_WAYS-1:0] way_match;

    // --------------------------------------------------
    // stage register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            stage_valid   <= 1'b0;
            stage_is_data <= 1'b0;
        end else if (~stall) begin
            stage_valid   <= first_try_ack | data_try_ack;
            stage_is_data <= data_try_ack;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall) begin
            stage_first <= first_try;
            stage_data  <= data_try;
        end
    end

    // --------------------------------------------------
    // saved responses, live only in the first cycle of an entry

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= ~stall;
        end
    end

    always_ff @(posedge CLK) begin
        if (first_cycle) begin
            saved_dtlb   <= dtlb_resp;
            saved_dcache <= dcache_resp;
        end
    end

    assign sel_dtlb   = first_cycle ? dtlb_resp : saved_dtlb;
    assign sel_dcache = first_cycle ? dcache_resp : saved_dcache;

    // --------------------------------------------------
    // translation and tag match

    assign cq_grab_index = stage_is_data ? stage_data.cq_index : stage_first.cq_index;

    always_comb begin
        dtlb_hit     = stage_is_data | sel_dtlb.hit;
        page_fault   = ~stage_is_data & sel_dtlb.page_fault;
        access_fault = ~stage_is_data & sel_dtlb.access_fault;

        // faulting loads carry the VPN so the VA can be rebuilt
        if (sel_dtlb.hit & ~page_fault & ~access_fault) begin
            ppn = sel_dtlb.ppn;
        end else begin
            ppn = ldu_pkg::ppn_t'(stage_first.vpn);
        end
        pa_word = {ppn, stage_first.po_word};
        pa_tag  = pa_word[ldu_pkg::PA_WORD_W-1 -: ldu_pkg::DCACHE_TAG_W];

        for (int way = 0; way < ldu_pkg::DCACHE_WAYS; way++) begin
            way_match[way] = sel_dcache.valid_by_way[way]
                & (sel_dcache.tag_by_way[way] == pa_tag);
        end
    end

    // --------------------------------------------------
    // entry for the return stage

    always_comb begin
        ret_entry.is_data      = stage_is_data;
        ret_entry.dtlb_hit     = dtlb_hit;
        ret_entry.dcache_hit   = dtlb_hit & (|way_match);
        ret_entry.page_fault   = page_fault;
        ret_entry.access_fault = access_fault;
        ret_entry.do_wb = stage_is_data
            | (dtlb_hit & (|way_match) & ~page_fault & ~access_fault);
        ret_entry.do_exception = dtlb_hit & (page_fault | access_fault);
        ret_entry.op           = cq_grab.op;
        ret_entry.dest_pr      = cq_grab.dest_pr;
        ret_entry.rob_index    = cq_grab.rob_index;
        ret_entry.pa_word      = pa_word;
        ret_entry.byte_mask    = stage_first.byte_mask;
        ret_entry.cq_index     = cq_grab_index;

        if (stage_is_data) begin
            ret_entry.data = stage_data.data;
        end else if (way_match[1]) begin
            ret_entry.data = sel_dcache.data_by_way[1];
        end else begin
            ret_entry.data = sel_dcache.data_by_way[0];
        end
    end

    assign ret_valid = stage_valid;

    // a line lives in at most one way of the set
    a_single_way: assert property (@(posedge CLK) disable iff (!nRST)
        stage_valid && !stage_is_data |-> !(&way_match));

endmodule

/* hdl/ldu_ret_stage.sv */
// return stage: drives writeback, ROB exception and cq return, stalls on back-pressure
`timescale 1ns/100ps

module ldu_ret_stage (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     resp_valid,
    input  ldu_pkg::ret_entry_t      resp_entry,
    input  logic                     wb_ready,
    input  logic                     rob_exception_ready,
    output logic                     stall,
    output logic                     wb_valid,
    output ldu_pkg::wb_t             wb,
    output logic                     rob_exception_valid,
    output ldu_pkg::rob_exception_t  rob_exception,
    output logic                     cq_ret_valid,
    output ldu_pkg::cq_ret_t         cq_ret
);

    logic                 stage_valid;
    ldu_pkg::ret_entry_t  entry;
    logic                 perform;
    ldu_pkg::word_t       wb_data;
    logic [1:0]           va_low;

    // --------------------------------------------------
    // stage register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            stage_valid <= 1'b0;
        end else if (~stall) begin
            stage_valid <= resp_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall) begin
            entry <= resp_entry;
        end
    end

    // --------------------------------------------------
    // perform and stall

    always_comb begin
        perform = stage_valid
            & ~(entry.do_wb & ~wb_ready)
            & ~(entry.do_exception & ~rob_exception_ready);
        stall = stage_valid & ~perform;
    end

    ldu_load_align u_align (
        .op        (entry.op),
        .byte_mask (entry.byte_mask),
        .is_data   (entry.is_data),
        .data      (entry.data),
        .wb_data   (wb_data)
    );

    // byte index of the lowest set mask bit
    always_comb begin
        if (entry.byte_mask[0]) begin
            va_low = 2'd0;
        end else if (entry.byte_mask[1]) begin
            va_low = 2'd1;
        end else if (entry.byte_mask[2]) begin
            va_low = 2'd2;
        end else if (entry.byte_mask[3]) begin
            va_low = 2'd3;
        end else begin
            va_low = 2'd0;
        end
    end

    // --------------------------------------------------
    // output ports

    always_comb begin
        wb_valid     = entry.do_wb & perform;
        wb.data      = wb_data;
        wb.pr        = entry.dest_pr;
        wb.rob_index = entry.rob_index;

        rob_exception_valid        = entry.do_exception & perform;
        rob_exception.va           = {entry.pa_word[29:0], va_low};
        rob_exception.page_fault   = entry.page_fault;
        rob_exception.access_fault = entry.access_fault;
        rob_exception.rob_index    = entry.rob_index;

        cq_ret_valid        = perform;
        cq_ret.wb_sent      = entry.do_wb;
        cq_ret.cq_index     = entry.cq_index;
        cq_ret.dtlb_hit     = entry.dtlb_hit;
        cq_ret.page_fault   = entry.page_fault;
        cq_ret.access_fault = entry.access_fault;
        cq_ret.dcache_hit   = entry.dcache_hit;
        cq_ret.pa_word      = entry.pa_word;
        cq_ret.byte_mask    = entry.byte_mask;
        cq_ret.data         = entry.data;
    end

    // response stage decides one action per load
    a_wb_xor_exc: assert property (@(posedge CLK) disable iff (!nRST)
        stage_valid |-> !(entry.do_wb && entry.do_exception));

endmodule

/* test/ldu_tb_ref.svh */
// reference functions for the testbench, included inside the testbench module
`ifndef LDU_TB_REF_SVH
`define LDU_TB_REF_SVH

// writeback value of a load, by op and byte mask
function automatic ldu_pkg::word_t load_result(input ldu_pkg::load_op_t op,
                                               input ldu_pkg::byte_mask_t mask,
                                               input ldu_pkg::word_t data);
    logic [15:0] h;
    logic [7:0]  b;
    logic        ext;
    if (op[1]) begin
        return data;
    end
    case (mask)
        4'b1100: h = data[31:16];
        4'b0110: h = data[23:8];
        default: h = data[15:0];
    endcase
    casez (mask)
        4'b1???: b = data[31:24];
        4'b01??: b = data[23:16];
        4'b001?: b = data[15:8];
        default: b = data[7:0];
    endcase
    if (op[0]) begin
        ext = h[15] & ~op[2];
        return {{16{ext}}, h};
    end
    ext = b[7] & ~op[2];
    return {{24{ext}}, b};
endfunction

// virtual address of a faulting load
function automatic ldu_pkg::va_t fault_va(input ldu_pkg::vpn_t vpn,
                                          input ldu_pkg::po_word_t po,
                                          input ldu_pkg::byte_mask_t mask);
    logic [1:0] idx;
    casez (mask)
        4'b???1: idx = 2'd0;
        4'b??10: idx = 2'd1;
        4'b?100: idx = 2'd2;
        4'b1000: idx = 2'd3;
        default: idx = 2'd0;
    endcase
    return {vpn, po, idx};
endfunction

`endif

/* test/ldu_tb.sv */
// testbench for the load launch pipeline: random tries, response models, result checks
`timescale 1ns/100ps

module ldu_tb;

    `include "ldu_tb_ref.svh"

    localparam int N_TRIES     = 140;
    localparam int WATCHDOG_NS = (N_TRIES * 20 + 100) * 10;

    int seed = 69;
    int try_count = 0;
    int k;

    logic CLK = 1'b0;
    logic nRST = 1'b0;
    logic first_try_valid, first_try_ack, data_try_valid, data_try_ack;
    logic dtlb_req_valid, dtlb_req_ready, dcache_req_valid, dcache_req_ready;
    logic wb_valid, wb_ready, rob_exception_valid, rob_exception_ready, cq_ret_valid;
    ldu_pkg::first_try_t     first_try;
    ldu_pkg::data_try_t      data_try;
    ldu_pkg::dtlb_req_t      dtlb_req;
    ldu_pkg::dtlb_resp_t     dtlb_resp;
    ldu_pkg::dcache_req_t    dcache_req;
    ldu_pkg::dcache_resp_t   dcache_resp;
    ldu_pkg::cq_index_t      cq_grab_index;
    ldu_pkg::cq_grab_t       cq_grab;
    ldu_pkg::wb_t            wb;
    ldu_pkg::rob_exception_t rob_exception;
    ldu_pkg::cq_ret_t        cq_ret;

    ldu_pkg::cq_grab_t       cq_table [8];
    ldu_pkg::wb_t            wb_q [$];
    ldu_pkg::rob_exception_t exc_q [$];
    ldu_pkg::cq_ret_t        cq_q [$];
    ldu_pkg::wb_t            exp_wb;
    ldu_pkg::rob_exception_t exp_exc;
    ldu_pkg::cq_ret_t        exp_cq;
    int                      cq_seen = 0;

    // scheduled dtlb and dcache responses
    logic                    resp_pending = 1'b0;
    logic                    bp_enable = 1'b0;
    ldu_pkg::dtlb_resp_t     next_dtlb;
    ldu_pkg::dcache_resp_t   next_dcache;

    ldu_launch_pipeline UUT (.*);

    always #5 CLK = ~CLK;

    assign cq_grab = cq_table[cq_grab_index];

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_wb(input ldu_pkg::wb_t got, input ldu_pkg::wb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: wb got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic compare_exc(input ldu_pkg::rob_exception_t got,
                               input ldu_pkg::rob_exception_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: rob_exception got %h expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic compare_cq_ret(input ldu_pkg::cq_ret_t got, input ldu_pkg::cq_ret_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: cq_ret got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic compare_dtlb_req(input ldu_pkg::dtlb_req_t got,
                                    input ldu_pkg::dtlb_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: dtlb_req got %h expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic compare_dcache_req(input ldu_pkg::dcache_req_t got,
                                      input ldu_pkg::dcache_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: dcache_req got %h expected %h",
                               $time, got, exp));
        end
    endtask

    // --------------------------------------------------
    // stimulus tasks

    // kind: 0 hit, 1 dcache miss, 2 dtlb miss, 3 page fault, 4 access fault
    task automatic send_first(input int kind, input logic with_data);
        ldu_pkg::first_try_t   ft;
        ldu_pkg::cq_grab_t     g;
        ldu_pkg::dtlb_resp_t   tr;
        ldu_pkg::dcache_resp_t cr;
        ldu_pkg::dtlb_req_t    exp_treq;
        ldu_pkg::dcache_req_t  exp_creq;
        ldu_pkg::ppn_t         pa_ppn;
        ldu_pkg::word_t        word;
        logic                  is_word, is_half, uns;
        logic [1:0]            sel;
        int                    w;
        is_word = 1'($random(seed));
        is_half = ~is_word & 1'($random(seed));
        uns = 1'($random(seed));
        sel = 2'($random(seed));
        ft.vpn = ldu_pkg::vpn_t'($random(seed));
        ft.po_word = ldu_pkg::po_word_t'($random(seed));
        ft.cq_index = try_count[2:0];
        if (is_word) begin
            ft.byte_mask = 4'b1111;
        end else if (is_half) begin
            ft.byte_mask = (sel == 0) ? 4'b1100 : (sel == 1) ? 4'b0110 : 4'b0011;
        end else begin
            ft.byte_mask = 4'b0001 << sel;
        end
        g.op = {1'b0, uns, is_word, is_half};
        g.dest_pr = ldu_pkg::pr_t'($random(seed));
        g.rob_index = ldu_pkg::rob_index_t'($random(seed));
        cq_table[ft.cq_index] = g;
        try_count++;

        // bank bit 3: offset from word bits 2:0, set index from word bits 9:4
        exp_treq.vpn = ft.vpn;
        exp_treq.cq_index = ft.cq_index;
        exp_creq.block_offset = {ft.po_word[2:0], 2'b00};
        exp_creq.index = {1'b0, ft.po_word[9:4]};
        exp_creq.cq_index = ft.cq_index;

        tr = '0;
        cr = '0;
        cr.data_by_way[0] = $random(seed);
        cr.data_by_way[1] = $random(seed);
        tr.hit = (kind != 2);
        tr.ppn = ldu_pkg::ppn_t'($random(seed));
        tr.page_fault = (kind == 3);
        tr.access_fault = (kind == 4);
        pa_ppn = (kind >= 2) ? ldu_pkg::ppn_t'(ft.vpn) : tr.ppn;
        w = $random(seed) & 1;
        // the tag matches in every kind except the dcache miss
        cr.valid_by_way = '1;
        cr.tag_by_way[w] = (kind == 1) ? ~pa_ppn : pa_ppn;
        cr.tag_by_way[1-w] = ~pa_ppn;
        word = (kind == 1) ? cr.data_by_way[0] : cr.data_by_way[w];

        exp_wb.data = load_result(g.op, ft.byte_mask, word);
        exp_wb.pr = g.dest_pr;
        exp_wb.rob_index = g.rob_index;
        exp_exc.va = fault_va(ft.vpn, ft.po_word, ft.byte_mask);
        exp_exc.page_fault = tr.page_fault;
        exp_exc.access_fault = tr.access_fault;
        exp_exc.rob_index = g.rob_index;
        exp_cq.wb_sent = (kind == 0);
        exp_cq.cq_index = ft.cq_index;
        exp_cq.dtlb_hit = tr.hit;
        exp_cq.page_fault = tr.page_fault;
        exp_cq.access_fault = tr.access_fault;
        exp_cq.dcache_hit = (kind == 0) || (kind >= 3);
        exp_cq.pa_word = {pa_ppn, ft.po_word};
        exp_cq.byte_mask = ft.byte_mask;
        exp_cq.data = word;

        if (with_data) begin
            data_try.data = $random(seed);
            data_try.cq_index = try_count[2:0];
            cq_table[data_try.cq_index] = '{op: 4'h0, dest_pr: ldu_pkg::pr_t'($random(seed)),
                                            rob_index: ldu_pkg::rob_index_t'($random(seed))};
            try_count++;
            data_try_valid = 1'b1;
        end
        first_try = ft;
        first_try_valid = 1'b1;
        do @(negedge CLK); while (!first_try_ack);
        if (with_data && data_try_ack) begin
            fail_run("data try was acked in the same cycle as a first try");
        end
        compare_dtlb_req(dtlb_req, exp_treq);
        compare_dcache_req(dcache_req, exp_creq);
        cq_q.push_back(exp_cq);
        if (kind == 0) wb_q.push_back(exp_wb);
        if (kind >= 3) exc_q.push_back(exp_exc);
        next_dtlb = tr;
        next_dcache = cr;
        resp_pending = 1'b1;
        @(posedge CLK);
        #1;
        first_try_valid = 1'b0;
        first_try = '0;
    endtask

    // preset: data try fields were already set up by a first try
    task automatic send_data(input logic preset);
        ldu_pkg::cq_grab_t g;
        if (!preset) begin
            data_try.data = $random(seed);
            data_try.cq_index = try_count[2:0];
            g.op = ldu_pkg::load_op_t'($random(seed));
            g.dest_pr = ldu_pkg::pr_t'($random(seed));
            g.rob_index = ldu_pkg::rob_index_t'($random(seed));
            cq_table[data_try.cq_index] = g;
            try_count++;
        end
        g = cq_table[data_try.cq_index];
        data_try_valid = 1'b1;
        do @(negedge CLK); while (!data_try_ack);
        exp_wb.data = data_try.data;
        exp_wb.pr = g.dest_pr;
        exp_wb.rob_index = g.rob_index;
        exp_cq = '0;
        exp_cq.wb_sent = 1'b1;
        exp_cq.cq_index = data_try.cq_index;
        exp_cq.dtlb_hit = 1'b1;
        exp_cq.data = data_try.data;
        wb_q.push_back(exp_wb);
        cq_q.push_back(exp_cq);
        @(posedge CLK);
        #1;
        data_try_valid = 1'b0;
    endtask

    // --------------------------------------------------
    // response model and ready drivers

    always @(posedge CLK) begin
        #1;
        if (resp_pending) begin
            dtlb_resp = next_dtlb;
            dcache_resp = next_dcache;
            resp_pending = 1'b0;
        end else begin
            dtlb_resp = '0;
            dcache_resp = '0;
        end
        if (bp_enable) begin
            wb_ready = 1'($random(seed));
            rob_exception_ready = 1'($random(seed));
            dtlb_req_ready = ($random(seed) & 3) != 0;
            dcache_req_ready = ($random(seed) & 3) != 0;
        end else begin
            wb_ready = 1'b1;
            rob_exception_ready = 1'b1;
            dtlb_req_ready = 1'b1;
            dcache_req_ready = 1'b1;
        end
    end

    // --------------------------------------------------
    // checker, outputs are stable at the falling edge

    always @(negedge CLK) begin
        if (nRST) begin
            if (first_try_ack && data_try_ack) fail_run("both tries acked in one cycle");
            if (dtlb_req_valid !== first_try_ack || dcache_req_valid !== first_try_ack) begin
                fail_run("dtlb or dcache request valid differs from the first-try ack");
            end
            if (UUT.stall && (first_try_ack || data_try_ack)) begin
                fail_run("a try was acked while an output was held unaccepted");
            end
            if (wb_valid && wb_ready) begin
                if (wb_q.size() == 0) fail_run("writeback with no load expecting one");
                compare_wb(wb, wb_q.pop_front());
            end
            if (rob_exception_valid && rob_exception_ready) begin
                if (exc_q.size() == 0) fail_run("exception with no load expecting one");
                compare_exc(rob_exception, exc_q.pop_front());
            end
            if (cq_ret_valid) begin
                if (cq_q.size() == 0) fail_run("cq return with no load outstanding");
                compare_cq_ret(cq_ret, cq_q.pop_front());
                cq_seen++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("timeout, the pipeline stopped returning results");
    end

    initial begin
        first_try_valid = 1'b0;
        first_try = '0;
        data_try_valid = 1'b0;
        data_try = '0;
        dtlb_req_ready = 1'b1;
        dcache_req_ready = 1'b1;
        dtlb_resp = '0;
        dcache_resp = '0;
        wb_ready = 1'b1;
        rob_exception_ready = 1'b1;
        for (int i = 0; i < 8; i++) cq_table[i] = '0;
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        repeat (30) send_first(0, 1'b0);
        repeat (6) send_first(1, 1'b0);
        repeat (6) send_first(2, 1'b0);
        repeat (6) send_first(3, 1'b0);
        repeat (6) send_first(4, 1'b0);
        repeat (8) send_data(1'b0);
        repeat (4) begin
            send_first(0, 1'b1);
            send_data(1'b1);
        end

        // random mix under back-pressure
        bp_enable = 1'b1;
        repeat (60) begin
            k = {$random(seed)} % 6;
            if (k == 5) send_data(1'b0);
            else send_first(k, 1'b0);
        end
        while (cq_q.size() != 0 || wb_q.size() != 0 || exc_q.size() != 0) @(negedge CLK);
        repeat (5) @(negedge CLK);

        if (cq_seen == try_count) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("number of cq returns differs from the number of tries");
        end
    end

endmodule
